// File: hdl/wh_link_pkg.sv
////////////////////////////////////////////////////////////
// wormhole link package
// flit, header flit and link bundle types for the
// cache wormhole side of the DMA bridge
////////////////////////////////////////////////////////////

package wh_link_pkg;

  // link flit width, also the DMA data width
  localparam int flit_width_c   = 32;
  localparam int cid_width_c    = 4;
  localparam int cord_width_c   = 6;
  // bounds the number of DMA ports at 4
  localparam int dma_id_width_c = 2;
  localparam int len_width_c    = 4;

  localparam int hdr_used_c = 1 + dma_id_width_c + cid_width_c + 2 * cord_width_c + len_width_c;

  typedef logic [flit_width_c-1:0] flit_t;

  // header flit, padding in the top bits
  typedef struct packed {
    logic [flit_width_c-hdr_used_c-1:0] unused;
    logic                               write_not_read;
    logic [dma_id_width_c-1:0]          dma_id;
    logic [cid_width_c-1:0]             cid;
    logic [cord_width_c-1:0]            src_cord;
    logic [cord_width_c-1:0]            dest_cord;
    logic [len_width_c-1:0]             len;
  } wh_header_t;

  typedef struct packed {
    logic  v;
    flit_t data;
  } wh_link_t;

endpackage

// File: hdl/cache_dma_pkg.sv
////////////////////////////////////////////////////////////
// cache DMA package
// opcode and packet types for the cache DMA ports
////////////////////////////////////////////////////////////

package cache_dma_pkg;

  // block address width
  localparam int addr_width_c = 12;

  typedef enum logic {
    DMA_READ  = 1'b0,
    DMA_WRITE = 1'b1
  } dma_op_e;

  // one DMA request, opcode over block address
  typedef struct packed {
    dma_op_e                 op;
    logic [addr_width_c-1:0] addr;
  } dma_pkt_t;

endpackage

// File: hdl/flit_fifo.sv
////////////////////////////////////////////////////////////
// flit FIFO
// circular flit buffer on the incoming link, valid/ready
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module flit_fifo
  import wh_link_pkg::*;
  #(parameter int fifo_els_p = 8)
  (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  in_v_i,
    input  flit_t in_flit_i,
    output logic  in_ready_o,
    output logic  out_v_o,
    output flit_t out_flit_o,
    input  logic  out_ready_i
  );

  localparam int ptr_w_lp = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
  localparam int cnt_w_lp = $clog2(fifo_els_p + 1);

  flit_t               mem_r [fifo_els_p];
  logic [ptr_w_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                en_r;
  logic                full, push, pop;

  assign full       = (count_r == cnt_w_lp'(fifo_els_p));
  // a pop frees the slot in the same cycle when full
  assign in_ready_o = en_r & (~full | out_ready_i);
  assign out_v_o    = (count_r != '0);
  assign out_flit_o = mem_r[rd_ptr_r];
  assign push       = in_v_i & in_ready_o;
  assign pop        = out_v_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      en_r     <= 1'b0;
    end else begin
      en_r <= 1'b1;
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + cnt_w_lp'(push) - cnt_w_lp'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= in_flit_i;
    end
  end

endmodule

// File: hdl/wh_dma_request_fsm.sv
////////////////////////////////////////////////////////////
// wormhole to DMA request FSM
// decodes request packets into DMA packets and evict data,
// keeps the per-port return tag table
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wh_dma_request_fsm
  import wh_link_pkg::*;
  import cache_dma_pkg::*;
  #(parameter int num_dma_p   = 4,
    parameter int block_len_p = 4)
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      flit_v_i,
    input  flit_t                     flit_i,
    output logic                      flit_ready_o,
    output logic [num_dma_p-1:0]      dma_pkt_v_o,
    output dma_pkt_t                  dma_pkt_o,
    input  logic [num_dma_p-1:0]      dma_pkt_ready_i,
    output logic [num_dma_p-1:0]      evict_v_o,
    output flit_t                     evict_data_o,
    input  logic [num_dma_p-1:0]      evict_ready_i,
    input  logic [dma_id_width_c-1:0] tag_sel_i,
    output logic [cid_width_c-1:0]    tag_cid_o,
    output logic [cord_width_c-1:0]   tag_cord_o
  );

  localparam int cnt_w_lp = (block_len_p > 1) ? $clog2(block_len_p) : 1;

  typedef enum logic [1:0] {
    IDLE,
    DMA_PKT,
    EVICT
  } req_state_e;

  req_state_e                state_r, state_n;
  wh_header_t                hdr_in;
  dma_op_e                   op_r;
  logic [dma_id_width_c-1:0] port_r;
  logic [cnt_w_lp-1:0]       beat_r;
  logic                      last_beat;
  logic                      tag_we;

  // return tags, one entry per port
  logic [cid_width_c-1:0]  cid_r  [num_dma_p];
  logic [cord_width_c-1:0] cord_r [num_dma_p];

  assign hdr_in     = flit_i;
  assign last_beat  = (beat_r == cnt_w_lp'(block_len_p - 1));
  assign tag_cid_o  = cid_r[tag_sel_i];
  assign tag_cord_o = cord_r[tag_sel_i];

  // address flit and evict data come straight off the FIFO head
  assign dma_pkt_o.op   = op_r;
  assign dma_pkt_o.addr = flit_i[addr_width_c-1:0];
  assign evict_data_o   = flit_i;

  always_comb begin
    state_n      = state_r;
    flit_ready_o = 1'b0;
    dma_pkt_v_o  = '0;
    evict_v_o    = '0;
    tag_we       = 1'b0;
    case (state_r)
      IDLE: begin
        flit_ready_o = 1'b1;
        if (flit_v_i) begin
          tag_we  = 1'b1;
          state_n = DMA_PKT;
        end
      end
      DMA_PKT: begin
        dma_pkt_v_o[port_r] = flit_v_i;
        flit_ready_o        = dma_pkt_ready_i[port_r];
        if (flit_v_i && dma_pkt_ready_i[port_r]) begin
          state_n = (op_r == DMA_WRITE) ? EVICT : IDLE;
        end
      end
      EVICT: begin
        evict_v_o[port_r] = flit_v_i;
        flit_ready_o      = evict_ready_i[port_r];
        if (flit_v_i && evict_ready_i[port_r] && last_beat) begin
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      op_r    <= DMA_READ;
      port_r  <= '0;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      if (tag_we) begin
        op_r   <= hdr_in.write_not_read ? DMA_WRITE : DMA_READ;
        port_r <= hdr_in.dma_id;
      end
      if (state_r == EVICT && flit_v_i && evict_ready_i[port_r]) begin
        beat_r <= last_beat ? '0 : beat_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_we) begin
      cid_r[hdr_in.dma_id]  <= hdr_in.cid;
      cord_r[hdr_in.dma_id] <= hdr_in.src_cord;
    end
  end

endmodule

// File: hdl/wh_dma_response_fsm.sv
////////////////////////////////////////////////////////////
// DMA to wormhole response FSM
// round-robin pick of ready fill data, sent back on the
// link as header plus data flits
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wh_dma_response_fsm
  import wh_link_pkg::*;
  #(parameter int num_dma_p   = 4,
    parameter int block_len_p = 4)
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [num_dma_p-1:0]      fill_v_i,
    input  flit_t                     fill_data_i [num_dma_p],
    output logic [num_dma_p-1:0]      fill_ready_o,
    output logic [dma_id_width_c-1:0] tag_sel_o,
    input  logic [cid_width_c-1:0]    tag_cid_i,
    input  logic [cord_width_c-1:0]   tag_cord_i,
    output wh_link_t                  link_o,
    input  logic                      link_ready_i
  );

  localparam int cnt_w_lp = (block_len_p > 1) ? $clog2(block_len_p) : 1;

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    FILL
  } resp_state_e;

  resp_state_e               state_r, state_n;
  // port being served, also the rotation base of the arbiter
  logic [dma_id_width_c-1:0] sel_r;
  logic [cnt_w_lp-1:0]       beat_r;
  logic                      last_beat;
  logic                      grant_v;
  logic [dma_id_width_c-1:0] grant_idx;
  logic                      fill_hs;
  wh_header_t                hdr_out;

  assign tag_sel_o = sel_r;
  assign last_beat = (beat_r == cnt_w_lp'(block_len_p - 1));
  assign fill_hs   = (state_r == FILL) & fill_v_i[sel_r] & link_ready_i;

  // rotating priority, the port after the last served one wins
  always_comb begin
    int idx;
    grant_v   = 1'b0;
    grant_idx = '0;
    for (int k = num_dma_p; k >= 1; k--) begin
      idx = (int'(sel_r) + k) % num_dma_p;
      if (fill_v_i[idx]) begin
        grant_v   = 1'b1;
        grant_idx = dma_id_width_c'(idx);
      end
    end
  end

  // response header from the stored tag
  always_comb begin
    hdr_out                = '0;
    hdr_out.dma_id         = sel_r;
    hdr_out.cid            = tag_cid_i;
    hdr_out.dest_cord      = tag_cord_i;
    hdr_out.len            = len_width_c'(block_len_p);
    hdr_out.write_not_read = 1'b0;
  end

  always_comb begin
    state_n      = state_r;
    link_o       = '0;
    fill_ready_o = '0;
    case (state_r)
      IDLE: begin
        if (grant_v) begin
          state_n = HEADER;
        end
      end
      HEADER: begin
        link_o.v    = 1'b1;
        link_o.data = hdr_out;
        if (link_ready_i) begin
          state_n = FILL;
        end
      end
      FILL: begin
        link_o.v             = fill_v_i[sel_r];
        link_o.data          = fill_data_i[sel_r];
        // stall the port together with the link
        fill_ready_o[sel_r]  = link_ready_i;
        if (fill_hs && last_beat) begin
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      sel_r   <= '0;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == IDLE && grant_v) begin
        sel_r <= grant_idx;
      end
      if (fill_hs) begin
        beat_r <= last_beat ? '0 : beat_r + 1'b1;
      end
    end
  end

endmodule

// File: hdl/dma_mem_model.sv
////////////////////////////////////////////////////////////
// DMA memory model
// block memory behind one DMA port, takes evict data and
// returns fill data
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module dma_mem_model
  import wh_link_pkg::*;
  import cache_dma_pkg::*;
  #(parameter int block_len_p  = 4,
    parameter int mem_blocks_p = 16)
  (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     pkt_v_i,
    input  dma_pkt_t pkt_i,
    output logic     pkt_ready_o,
    input  logic     evict_v_i,
    input  flit_t    evict_data_i,
    output logic     evict_ready_o,
    output logic     fill_v_o,
    output flit_t    fill_data_o,
    input  logic     fill_ready_i
  );

  localparam int cnt_w_lp = (block_len_p > 1) ? $clog2(block_len_p) : 1;
  localparam int blk_w_lp = (mem_blocks_p > 1) ? $clog2(mem_blocks_p) : 1;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ
  } mem_state_e;

  mem_state_e          state_r;
  logic [blk_w_lp-1:0] blk_r;
  logic [cnt_w_lp-1:0] beat_r;
  logic                last_beat;

  flit_t mem_r [mem_blocks_p][block_len_p];

  assign last_beat     = (beat_r == cnt_w_lp'(block_len_p - 1));
  assign pkt_ready_o   = (state_r == IDLE);
  assign evict_ready_o = (state_r == WRITE);
  assign fill_v_o      = (state_r == READ);
  // held until the response side takes it
  assign fill_data_o   = mem_r[blk_r][beat_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      beat_r  <= '0;
      blk_r   <= '0;
    end else begin
      case (state_r)
        IDLE: begin
          if (pkt_v_i) begin
            // low address bits pick the block
            blk_r   <= pkt_i.addr[blk_w_lp-1:0];
            beat_r  <= '0;
            state_r <= (pkt_i.op == DMA_WRITE) ? WRITE : READ;
          end
        end
        WRITE: begin
          if (evict_v_i) begin
            beat_r <= last_beat ? '0 : beat_r + 1'b1;
            if (last_beat) begin
              state_r <= IDLE;
            end
          end
        end
        READ: begin
          if (fill_ready_i) begin
            beat_r <= last_beat ? '0 : beat_r + 1'b1;
            if (last_beat) begin
              state_r <= IDLE;
            end
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == WRITE && evict_v_i) begin
      mem_r[blk_r][beat_r] <= evict_data_i;
    end
  end

endmodule

// File: hdl/wh_dma_top.sv
////////////////////////////////////////////////////////////
// wormhole to cache DMA bridge top
// input FIFO, request and response FSMs, memory per port
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wh_dma_top
  import wh_link_pkg::*;
  import cache_dma_pkg::*;
  #(parameter int num_dma_p    = 4,
    parameter int block_len_p  = 4,
    parameter int fifo_els_p   = 8,
    parameter int mem_blocks_p = 16)
  (
    input  logic     clk_i,
    input  logic     reset_i,
    input  wh_link_t link_i,
    output logic     flit_ready_o,
    output wh_link_t link_o,
    input  logic     link_ready_i
  );

  logic                      head_v, head_ready;
  flit_t                     head_flit;
  logic [num_dma_p-1:0]      dma_pkt_v, dma_pkt_ready;
  dma_pkt_t                  dma_pkt;
  logic [num_dma_p-1:0]      evict_v, evict_ready;
  flit_t                     evict_data;
  logic [num_dma_p-1:0]      fill_v, fill_ready;
  flit_t                     fill_data [num_dma_p];
  logic [dma_id_width_c-1:0] tag_sel;
  logic [cid_width_c-1:0]    tag_cid;
  logic [cord_width_c-1:0]   tag_cord;

  flit_fifo #(.fifo_els_p(fifo_els_p)) in_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .in_v_i(link_i.v), .in_flit_i(link_i.data), .in_ready_o(flit_ready_o),
    .out_v_o(head_v), .out_flit_o(head_flit), .out_ready_i(head_ready)
  );

  wh_dma_request_fsm #(.num_dma_p(num_dma_p), .block_len_p(block_len_p)) req_fsm (
    .clk_i(clk_i), .reset_i(reset_i),
    .flit_v_i(head_v), .flit_i(head_flit), .flit_ready_o(head_ready),
    .dma_pkt_v_o(dma_pkt_v), .dma_pkt_o(dma_pkt), .dma_pkt_ready_i(dma_pkt_ready),
    .evict_v_o(evict_v), .evict_data_o(evict_data), .evict_ready_i(evict_ready),
    .tag_sel_i(tag_sel), .tag_cid_o(tag_cid), .tag_cord_o(tag_cord)
  );

  wh_dma_response_fsm #(.num_dma_p(num_dma_p), .block_len_p(block_len_p)) resp_fsm (
    .clk_i(clk_i), .reset_i(reset_i),
    .fill_v_i(fill_v), .fill_data_i(fill_data), .fill_ready_o(fill_ready),
    .tag_sel_o(tag_sel), .tag_cid_i(tag_cid), .tag_cord_i(tag_cord),
    .link_o(link_o), .link_ready_i(link_ready_i)
  );

  // one memory model per DMA port
  for (genvar i = 0; i < num_dma_p; i++) begin : g_mem
    dma_mem_model #(.block_len_p(block_len_p), .mem_blocks_p(mem_blocks_p)) mem (
      .clk_i(clk_i), .reset_i(reset_i),
      .pkt_v_i(dma_pkt_v[i]), .pkt_i(dma_pkt), .pkt_ready_o(dma_pkt_ready[i]),
      .evict_v_i(evict_v[i]), .evict_data_i(evict_data), .evict_ready_o(evict_ready[i]),
      .fill_v_o(fill_v[i]), .fill_data_o(fill_data[i]), .fill_ready_i(fill_ready[i])
    );
  end

endmodule

// File: testbench/tb_wh_dma.sv
////////////////////////////////////////////////////////////
// wormhole DMA bridge testbench
// drives request packets from the stimulus file and checks
// the response packets coming back on the link
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_wh_dma
  import wh_link_pkg::*;
  ();

  localparam int          num_dma_c        = 4;
  localparam int          block_len_c      = 4;
  localparam int          num_cid_c        = 1 << cid_width_c;
  // op, port, cid, src_cord, address, then the data words
  localparam int          rec_words_c      = 5 + block_len_c;
  localparam int          max_recs_c       = 32;
  localparam int          cycles_per_rec_c = 200;
  localparam logic [31:0] end_mark_c       = 32'hff;

  logic     clk_i;
  logic     reset_i;
  wh_link_t link_i;
  logic     flit_ready_o;
  wh_link_t link_o;
  logic     link_ready_i;

  logic [31:0] stim_mem [max_recs_c*rec_words_c];
  int          num_recs;
  int          num_reads;
  int          resp_count;
  integer      seed = 32'h9108_e2a6;

  // outstanding reads indexed by cid
  logic                      exp_valid [num_cid_c];
  logic [dma_id_width_c-1:0] exp_port  [num_cid_c];
  wh_header_t                exp_head  [num_cid_c];
  int                        exp_rec   [num_cid_c];
  flit_t                     exp_data  [num_cid_c][block_len_c];
  logic [num_dma_c-1:0]      port_busy;

  wh_dma_top #(
    .num_dma_p(num_dma_c),
    .block_len_p(block_len_c),
    .fifo_els_p(8),
    .mem_blocks_p(16)
  ) uut (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .link_i(link_i),
    .flit_ready_o(flit_ready_o),
    .link_o(link_o),
    .link_ready_i(link_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_header(input string name, input wh_header_t exp, input wh_header_t act);
    if (act.cid !== exp.cid || act.dest_cord !== exp.dest_cord || act.len !== exp.len) begin
      stop_with_failure($sformatf(
        "ERROR %s: expected cid=%h cord=%h len=%h, actual cid=%h cord=%h len=%h",
        name, exp.cid, exp.dest_cord, exp.len, act.cid, act.dest_cord, act.len));
    end
  endtask

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // holds the flit until the FIFO takes it and returns 1 ns after that edge
  task automatic send_flit(input flit_t f);
    logic taken;
    link_i.v    = 1'b1;
    link_i.data = f;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = flit_ready_o;
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic get_flit(output flit_t f);
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      seen = link_o.v & link_ready_i;
    end
    f = link_o.data;
  endtask

  task automatic send_request(input int r);
    wh_header_t hdr;
    int         base;
    int         port;
    int         cid;
    logic       wr;
    base = r * rec_words_c;
    wr   = stim_mem[base][0];
    port = int'(stim_mem[base+1][dma_id_width_c-1:0]);
    cid  = int'(stim_mem[base+2][cid_width_c-1:0]);
    // the tag table keeps one entry per port
    while (port_busy[port]) begin
      @(posedge clk_i);
      #1;
    end
    hdr                = '0;
    hdr.write_not_read = wr;
    hdr.dma_id         = stim_mem[base+1][dma_id_width_c-1:0];
    hdr.cid            = stim_mem[base+2][cid_width_c-1:0];
    hdr.src_cord       = stim_mem[base+3][cord_width_c-1:0];
    hdr.len            = wr ? len_width_c'(block_len_c + 1) : len_width_c'(1);
    if (!wr) begin
      if (exp_valid[cid]) begin
        stop_with_failure($sformatf("record %0d reuses cid %0h while it is outstanding", r, cid));
      end
      exp_valid[cid]          = 1'b1;
      exp_port[cid]           = stim_mem[base+1][dma_id_width_c-1:0];
      // response goes back to the requester with one block of data
      exp_head[cid]           = '0;
      exp_head[cid].cid       = hdr.cid;
      exp_head[cid].dest_cord = hdr.src_cord;
      exp_head[cid].len       = len_width_c'(block_len_c);
      exp_rec[cid]            = r;
      for (int b = 0; b < block_len_c; b++) begin
        exp_data[cid][b] = stim_mem[base+5+b];
      end
      port_busy[port] = 1'b1;
    end
    send_flit(hdr);
    send_flit(stim_mem[base+4]);
    if (wr) begin
      for (int b = 0; b < block_len_c; b++) begin
        send_flit(stim_mem[base+5+b]);
      end
    end
    link_i.v = 1'b0;
  endtask

  // back-pressure on the outgoing link is low about one cycle in four
  initial begin
    link_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      link_ready_i = (($random(seed) & 3) != 0);
    end
  end

  initial begin : response_checker
    flit_t      f;
    wh_header_t hdr;
    int         cid;
    forever begin
      get_flit(f);
      hdr = f;
      cid = int'(hdr.cid);
      if (!exp_valid[cid]) begin
        stop_with_failure($sformatf("response arrived for cid %0h with no read outstanding", cid));
      end
      check_header($sformatf("record %0d header", exp_rec[cid]), exp_head[cid], hdr);
      // data must follow the header with no other packet in between
      for (int b = 0; b < block_len_c; b++) begin
        get_flit(f);
        check_flit($sformatf("record %0d data %0d", exp_rec[cid], b), exp_data[cid][b], f);
      end
      exp_valid[cid]           = 1'b0;
      port_busy[exp_port[cid]] = 1'b0;
      resp_count++;
    end
  end

  initial begin : watchdog
    @(negedge reset_i);
    repeat (num_recs * cycles_per_rec_c) @(posedge clk_i);
    stop_with_failure($sformatf("run timed out with %0d of %0d responses received",
                                resp_count, num_reads));
  end

  initial begin : driver
    reset_i    = 1'b1;
    link_i     = '0;
    port_busy  = '0;
    resp_count = 0;
    num_reads  = 0;
    num_recs   = 0;
    for (int c = 0; c < num_cid_c; c++) begin
      exp_valid[c] = 1'b0;
    end
    $readmemh("testbench/wh_dma_stimulus.txt", stim_mem);
    while (num_recs < max_recs_c && stim_mem[num_recs*rec_words_c] !== end_mark_c) begin
      if (stim_mem[num_recs*rec_words_c][0] == 1'b0) begin
        num_reads++;
      end
      num_recs++;
    end
    if (num_recs == 0) begin
      stop_with_failure("the stimulus file holds no records");
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (int r = 0; r < num_recs; r++) begin
      send_request(r);
    end
    while (resp_count < num_reads) begin
      @(posedge clk_i);
    end
    // a stray response from a write would show up in this quiet period
    repeat (4 * block_len_c + 8) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: testbench/wh_dma_stimulus.txt
// op (1 write, 0 read), dma port, cid, src_cord, block address, data words 0 to 3
// a read lists the data expected back; ff ends the list
1 0 0 05 003 a0000030 a0000031 a0000032 a0000033
1 1 0 06 003 b1000030 b1000031 b1000032 b1000033
1 2 0 07 003 c2000030 c2000031 c2000032 c2000033
1 3 0 08 003 d3000030 d3000031 d3000032 d3000033
0 0 1 11 003 a0000030 a0000031 a0000032 a0000033
0 1 2 12 003 b1000030 b1000031 b1000032 b1000033
0 2 3 13 003 c2000030 c2000031 c2000032 c2000033
0 3 4 14 003 d3000030 d3000031 d3000032 d3000033
1 0 0 15 007 a0000070 a0000071 a0000072 a0000073
0 0 5 21 007 a0000070 a0000071 a0000072 a0000073
1 2 0 16 00a c20000a0 c20000a1 c20000a2 c20000a3
0 2 6 22 00a c20000a0 c20000a1 c20000a2 c20000a3
0 1 7 23 003 b1000030 b1000031 b1000032 b1000033
0 3 8 24 003 d3000030 d3000031 d3000032 d3000033
1 1 0 17 003 5eed0001 5eed0002 5eed0003 5eed0004
0 1 9 25 003 5eed0001 5eed0002 5eed0003 5eed0004
0 0 a 2a 003 a0000030 a0000031 a0000032 a0000033
0 2 b 30 003 c2000030 c2000031 c2000032 c2000033
ff

// File: compile.f
hdl/wh_link_pkg.sv
hdl/cache_dma_pkg.sv
hdl/flit_fifo.sv
hdl/wh_dma_request_fsm.sv
hdl/wh_dma_response_fsm.sv
hdl/dma_mem_model.sv
hdl/wh_dma_top.sv
testbench/tb_wh_dma.sv

// File: Makefile
# Verilator build and run of the wormhole DMA bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_wh_dma
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
